// ==== source/cpu_pkg.sv ====
package cpu_pkg;

	// datapath and instruction word width
	localparam int WORD_W = 16;
	// eight general registers
	localparam int REG_W = 3;

	//////////////////////////////////////////////////////////////////////
	// opcodes, top five bits of every instruction
	//////////////////////////////////////////////////////////////////////

	// all-zero word is a nop
	localparam logic [4:0] OP_NOP   = 5'd0;
	// R format
	localparam logic [4:0] OP_ADDU  = 5'd1;
	localparam logic [4:0] OP_SUBU  = 5'd2;
	localparam logic [4:0] OP_AND   = 5'd3;
	localparam logic [4:0] OP_OR    = 5'd4;
	localparam logic [4:0] OP_SLT   = 5'd5;
	// I format
	localparam logic [4:0] OP_ADDIU = 5'd6;
	localparam logic [4:0] OP_LW    = 5'd7;
	localparam logic [4:0] OP_SW    = 5'd8;
	localparam logic [4:0] OP_BEQZ  = 5'd9;

	// one word, two field layouts
	typedef union packed {
		// rd = rs op rt
		struct packed {
			logic [4:0]       opcode;
			logic [REG_W-1:0] rd;
			logic [REG_W-1:0] rs;
			logic [REG_W-1:0] rt;
			logic [1:0]       spare;
		} r;
		// rx is dest or store data, ry is base or branch operand
		struct packed {
			logic [4:0]       opcode;
			logic [REG_W-1:0] rx;
			logic [REG_W-1:0] ry;
			logic [4:0]       imm;
		} i;
	} instr_t;

	// alu function select, decode to execute
	localparam logic [2:0] ALU_ADD = 3'd0;
	localparam logic [2:0] ALU_SUB = 3'd1;
	localparam logic [2:0] ALU_AND = 3'd2;
	localparam logic [2:0] ALU_OR  = 3'd3;
	localparam logic [2:0] ALU_SLT = 3'd4;

endpackage

// ==== source/hazard_if.sv ====
`timescale 1ns/1ns

interface hazard_if
	import cpu_pkg::*;
();

	// from hazard unit
	logic              stall_pc;
	logic              stall_if;
	logic              bubble_id;
	// branch resolved in decode
	logic              branch_taken;
	logic [WORD_W-1:0] branch_target;

	modport ctrl (
		output stall_pc,
		output stall_if,
		output bubble_id
	);

	modport fetch (
		input stall_pc,
		input stall_if,
		input branch_taken,
		input branch_target
	);

	modport decode (
		input  bubble_id,
		output branch_taken,
		output branch_target
	);

endinterface

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage
	import cpu_pkg::*;
#(
	parameter logic [WORD_W-1:0] PC_RESET = '0
) (
	input  logic              clk,
	input  logic              reset_i,
	hazard_if.fetch           hz,
	output logic [WORD_W-1:0] imem_addr_o,
	input  logic [WORD_W-1:0] imem_data_i,
	output logic [WORD_W-1:0] instr_o,
	output logic [WORD_W-1:0] pc_next_o
);

	logic [WORD_W-1:0] pc_q;
	logic [WORD_W-1:0] pc_inc;

	// imem answers in the same cycle
	assign imem_addr_o = pc_q;
	assign pc_inc      = pc_q + 1'b1;

	// pc
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= PC_RESET;
		end else if (hz.branch_taken) begin
			// redirect, never raised together with a stall
			pc_q <= hz.branch_target;
		end else if (!hz.stall_pc) begin
			pc_q <= pc_inc;
		end
	end

	// IF/ID instruction
	// taken branch kills the wrong-path fetch
	always_ff @(posedge clk) begin
		if (reset_i || hz.branch_taken) begin
			instr_o <= {OP_NOP, {(WORD_W-5){1'b0}}};
		end else if (!hz.stall_if) begin
			instr_o <= imem_data_i;
		end
	end

	// IF/ID pc+1, base of beqz target
	always_ff @(posedge clk) begin
		if (!hz.stall_if) begin
			pc_next_o <= pc_inc;
		end
	end

endmodule

// ==== source/register_file.sv ====
`timescale 1ns/1ns

module register_file
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_i,
	input  logic [REG_W-1:0]  rd_a_idx_i,
	input  logic [REG_W-1:0]  rd_b_idx_i,
	output logic [WORD_W-1:0] rd_a_o,
	output logic [WORD_W-1:0] rd_b_o,
	input  logic              wr_en_i,
	input  logic [REG_W-1:0]  wr_idx_i,
	input  logic [WORD_W-1:0] wr_data_i
);

	logic [WORD_W-1:0] regs_q [2**REG_W];

	// no hardwired zero, all eight writable
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int k = 0; k < 2**REG_W; k++) begin
				regs_q[k] <= '0;
			end
		end else if (wr_en_i) begin
			regs_q[wr_idx_i] <= wr_data_i;
		end
	end

	// write-through, wb value seen by decode in the same cycle
	assign rd_a_o = (wr_en_i && wr_idx_i == rd_a_idx_i) ? wr_data_i : regs_q[rd_a_idx_i];
	assign rd_b_o = (wr_en_i && wr_idx_i == rd_b_idx_i) ? wr_data_i : regs_q[rd_b_idx_i];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_i,
	hazard_if.decode          hz,
	input  instr_t            instr_i,
	input  logic [WORD_W-1:0] pc_next_i,
	// EX/MEM alu result, for beqz
	input  logic              fwd_en_i,
	input  logic [REG_W-1:0]  fwd_idx_i,
	input  logic [WORD_W-1:0] fwd_data_i,
	// register file write port
	input  logic              wb_en_i,
	input  logic [REG_W-1:0]  wb_idx_i,
	input  logic [WORD_W-1:0] wb_data_i,
	// to hazard unit
	output logic [REG_W-1:0]  src_a_idx_o,
	output logic [REG_W-1:0]  src_b_idx_o,
	output logic              is_branch_o,
	// ID/EX
	output logic [2:0]        alu_op_o,
	output logic [WORD_W-1:0] op_a_o,
	output logic [WORD_W-1:0] op_b_o,
	output logic              imm_sel_o,
	output logic [REG_W-1:0]  src_a_o,
	output logic [REG_W-1:0]  src_b_o,
	output logic [WORD_W-1:0] store_data_o,
	output logic [REG_W-1:0]  dst_o,
	output logic              reg_write_o,
	output logic              mem_read_o,
	output logic              mem_write_o
);

	logic              is_r;
	logic              reg_write;
	logic              mem_read;
	logic              mem_write;
	logic [2:0]        alu_op;
	logic [REG_W-1:0]  dst;
	logic [WORD_W-1:0] imm_ext;
	logic [WORD_W-1:0] rf_a;
	logic [WORD_W-1:0] rf_b;
	logic [WORD_W-1:0] ry_val;

	//////////////////////////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		is_r        = 1'b0;
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		is_branch_o = 1'b0;
		case (instr_i.r.opcode)
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT: begin
				is_r      = 1'b1;
				reg_write = 1'b1;
			end
			OP_ADDIU: begin
				reg_write = 1'b1;
			end
			OP_LW: begin
				reg_write = 1'b1;
				mem_read  = 1'b1;
			end
			OP_SW: begin
				mem_write = 1'b1;
			end
			OP_BEQZ: begin
				is_branch_o = 1'b1;
			end
			// nop and unused codes do nothing
			OP_NOP: begin
			end
			default: begin
			end
		endcase
		// I format always adds
		case (instr_i.r.opcode)
			OP_SUBU: alu_op = ALU_SUB;
			OP_AND:  alu_op = ALU_AND;
			OP_OR:   alu_op = ALU_OR;
			OP_SLT:  alu_op = ALU_SLT;
			default: alu_op = ALU_ADD;
		endcase
	end

	// sign-extended 5-bit immediate
	assign imm_ext = {{(WORD_W-5){instr_i.i.imm[4]}}, instr_i.i.imm};

	// port a: rs or ry (base, addend, branch operand)
	assign src_a_idx_o = is_r ? instr_i.r.rs : instr_i.i.ry;
	// port b: rt, rx for sw, else ry again so no false match
	assign src_b_idx_o = is_r ? instr_i.r.rt : (mem_write ? instr_i.i.rx : instr_i.i.ry);
	assign dst         = is_r ? instr_i.r.rd : instr_i.i.rx;

	register_file _regfile (
		.clk        (clk),
		.reset_i    (reset_i),
		.rd_a_idx_i (src_a_idx_o),
		.rd_b_idx_i (src_b_idx_o),
		.rd_a_o     (rf_a),
		.rd_b_o     (rf_b),
		.wr_en_i    (wb_en_i),
		.wr_idx_i   (wb_idx_i),
		.wr_data_i  (wb_data_i)
	);

	//////////////////////////////////////////////////////////////////////
	// beqz, resolved here
	//////////////////////////////////////////////////////////////////////

	// producer in EX/MEM wins, wb handled by file bypass
	assign ry_val = (fwd_en_i && fwd_idx_i == src_a_idx_o) ? fwd_data_i : rf_a;

	// no redirect while held for an operand
	assign hz.branch_taken  = is_branch_o && ry_val == '0 && !hz.bubble_id;
	assign hz.branch_target = pc_next_i + imm_ext;

	// ID/EX control, bubble is a nop
	always_ff @(posedge clk) begin
		if (reset_i || hz.bubble_id) begin
			reg_write_o <= 1'b0;
			mem_read_o  <= 1'b0;
			mem_write_o <= 1'b0;
		end else begin
			reg_write_o <= reg_write;
			mem_read_o  <= mem_read;
			mem_write_o <= mem_write;
		end
	end

	// ID/EX payload
	always_ff @(posedge clk) begin
		alu_op_o     <= alu_op;
		op_a_o       <= rf_a;
		op_b_o       <= imm_ext;
		imm_sel_o    <= !is_r;
		src_a_o      <= src_a_idx_o;
		src_b_o      <= src_b_idx_o;
		store_data_o <= rf_b;
		dst_o        <= dst;
	end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_i,
	// ID/EX
	input  logic [2:0]        alu_op_i,
	input  logic [WORD_W-1:0] op_a_i,
	input  logic [WORD_W-1:0] op_b_i,
	input  logic              imm_sel_i,
	input  logic [REG_W-1:0]  src_a_i,
	input  logic [REG_W-1:0]  src_b_i,
	input  logic [WORD_W-1:0] store_data_i,
	input  logic [REG_W-1:0]  dst_i,
	input  logic              reg_write_i,
	input  logic              mem_read_i,
	input  logic              mem_write_i,
	// MEM/WB forward
	input  logic              wb_en_i,
	input  logic [REG_W-1:0]  wb_idx_i,
	input  logic [WORD_W-1:0] wb_data_i,
	// EX/MEM
	output logic [WORD_W-1:0] alu_res_o,
	output logic [WORD_W-1:0] store_data_o,
	output logic [REG_W-1:0]  dst_o,
	output logic              reg_write_o,
	output logic              mem_read_o,
	output logic              mem_write_o
);

	logic [WORD_W-1:0] a_fwd;
	logic [WORD_W-1:0] b_fwd;
	logic [WORD_W-1:0] alu_b;
	logic [WORD_W-1:0] alu_res;

	// younger producer first: EX/MEM, then MEM/WB, then ID/EX copy
	// a lw in EX/MEM never reaches here, load-use stall
	function automatic logic [WORD_W-1:0] pick_operand(
		input logic [REG_W-1:0]  idx,
		input logic [WORD_W-1:0] id_val
	);
		if (reg_write_o && dst_o == idx) begin
			return alu_res_o;
		end else if (wb_en_i && wb_idx_i == idx) begin
			return wb_data_i;
		end
		return id_val;
	endfunction

	always_comb begin
		a_fwd = pick_operand(src_a_i, op_a_i);
		// port b also carries sw data
		b_fwd = pick_operand(src_b_i, store_data_i);
	end

	assign alu_b = imm_sel_i ? op_b_i : b_fwd;

	// alu
	always_comb begin
		case (alu_op_i)
			ALU_SUB: alu_res = a_fwd - alu_b;
			ALU_AND: alu_res = a_fwd & alu_b;
			ALU_OR:  alu_res = a_fwd | alu_b;
			// signed compare, 1 or 0
			ALU_SLT: alu_res = {{(WORD_W-1){1'b0}}, $signed(a_fwd) < $signed(alu_b)};
			default: alu_res = a_fwd + alu_b;
		endcase
	end

	// EX/MEM control
	always_ff @(posedge clk) begin
		if (reset_i) begin
			reg_write_o <= 1'b0;
			mem_read_o  <= 1'b0;
			mem_write_o <= 1'b0;
		end else begin
			reg_write_o <= reg_write_i;
			mem_read_o  <= mem_read_i;
			mem_write_o <= mem_write_i;
		end
	end

	// EX/MEM payload
	always_ff @(posedge clk) begin
		alu_res_o    <= alu_res;
		store_data_o <= b_fwd;
		dst_o        <= dst_i;
	end

endmodule

// ==== source/memory_writeback.sv ====
`timescale 1ns/1ns

module memory_writeback
	import cpu_pkg::*;
(
	input  logic              clk,
	input  logic              reset_i,
	// EX/MEM
	input  logic [WORD_W-1:0] alu_res_i,
	input  logic [WORD_W-1:0] store_data_i,
	input  logic [REG_W-1:0]  dst_i,
	input  logic              reg_write_i,
	input  logic              mem_read_i,
	input  logic              mem_write_i,
	// data memory
	output logic [WORD_W-1:0] dmem_addr_o,
	output logic [WORD_W-1:0] dmem_wdata_o,
	output logic              dmem_we_o,
	output logic              dmem_re_o,
	input  logic [WORD_W-1:0] dmem_rdata_i,
	// MEM/WB, also register file write
	output logic              wb_en_o,
	output logic [REG_W-1:0]  wb_idx_o,
	output logic [WORD_W-1:0] wb_data_o
);

	// alu result is the effective address
	assign dmem_addr_o  = alu_res_i;
	assign dmem_wdata_o = store_data_i;
	// write lands at the edge closing this cycle
	assign dmem_we_o    = mem_write_i;
	assign dmem_re_o    = mem_read_i;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wb_en_o <= 1'b0;
		end else begin
			wb_en_o <= reg_write_i;
		end
	end

	// wb mux ahead of the register, load data or alu
	always_ff @(posedge clk) begin
		wb_idx_o  <= dst_i;
		wb_data_o <= mem_read_i ? dmem_rdata_i : alu_res_i;
	end

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit
	import cpu_pkg::*;
(
	input  logic             clk,
	input  logic             reset_i,
	hazard_if.ctrl           hz,
	// instruction in ID
	input  logic [REG_W-1:0] src_a_idx_i,
	input  logic [REG_W-1:0] src_b_idx_i,
	input  logic             id_is_branch_i,
	// instruction in EX
	input  logic [REG_W-1:0] idex_dst_i,
	input  logic             idex_write_i,
	input  logic             idex_load_i,
	// instruction in MEM
	input  logic [REG_W-1:0] exmem_dst_i,
	input  logic             exmem_load_i
);

	logic load_use;
	logic branch_ex;
	logic branch_mem;
	logic stall;

	// lw result not ready for a consumer right behind it
	assign load_use = idex_load_i &&
		(idex_dst_i == src_a_idx_i || idex_dst_i == src_b_idx_i);
	// beqz needs ry in decode, producer still in EX
	assign branch_ex = id_is_branch_i && idex_write_i && idex_dst_i == src_a_idx_i;
	// lw in MEM, data only via file bypass next cycle
	assign branch_mem = id_is_branch_i && exmem_load_i && exmem_dst_i == src_a_idx_i;

	// each stall leaves a bubble in ID/EX
	// worst case lw then beqz holds two cycles
	assign stall = load_use || branch_ex || branch_mem;

	// freeze front end, nop into ID/EX
	assign hz.stall_pc  = stall;
	assign hz.stall_if  = stall;
	assign hz.bubble_id = stall;

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top
	import cpu_pkg::*;
#(
	parameter logic [WORD_W-1:0] PC_RESET = '0
) (
	input  logic              clk,
	input  logic              reset_i,
	// instruction memory
	output logic [WORD_W-1:0] imem_addr_o,
	input  logic [WORD_W-1:0] imem_data_i,
	// data memory
	output logic [WORD_W-1:0] dmem_addr_o,
	output logic [WORD_W-1:0] dmem_wdata_o,
	output logic              dmem_we_o,
	output logic              dmem_re_o,
	input  logic [WORD_W-1:0] dmem_rdata_i,
	// retirement, same as register file write
	output logic              wb_en_o,
	output logic [REG_W-1:0]  wb_reg_o,
	output logic [WORD_W-1:0] wb_data_o
);

	// stall, bubble and redirect
	hazard_if hz ();

	//////////////////////////////////////////////////////////////////////
	// IF, IF/ID
	//////////////////////////////////////////////////////////////////////

	logic [WORD_W-1:0] instr_ifid;
	logic [WORD_W-1:0] pc_next_ifid;

	fetch_stage #(
		.PC_RESET (PC_RESET)
	) _fetch (
		.clk         (clk),
		.reset_i     (reset_i),
		.hz          (hz),
		.imem_addr_o (imem_addr_o),
		.imem_data_i (imem_data_i),
		.instr_o     (instr_ifid),
		.pc_next_o   (pc_next_ifid)
	);

	//////////////////////////////////////////////////////////////////////
	// ID, ID/EX
	//////////////////////////////////////////////////////////////////////

	// sources of the instruction in ID
	logic [REG_W-1:0]  src_a_idx_id;
	logic [REG_W-1:0]  src_b_idx_id;
	logic              is_branch_id;
	// ID/EX
	logic [2:0]        alu_op_idex;
	logic [WORD_W-1:0] op_a_idex;
	logic [WORD_W-1:0] op_b_idex;
	logic              imm_sel_idex;
	logic [REG_W-1:0]  src_a_idex;
	logic [REG_W-1:0]  src_b_idex;
	logic [WORD_W-1:0] store_data_idex;
	logic [REG_W-1:0]  dst_idex;
	logic              reg_write_idex;
	logic              mem_read_idex;
	logic              mem_write_idex;
	// EX/MEM
	logic [WORD_W-1:0] alu_res_exmem;
	logic [WORD_W-1:0] store_data_exmem;
	logic [REG_W-1:0]  dst_exmem;
	logic              reg_write_exmem;
	logic              mem_read_exmem;
	logic              mem_write_exmem;

	decode_stage _decode (
		.clk          (clk),
		.reset_i      (reset_i),
		.hz           (hz),
		.instr_i      (instr_ifid),
		.pc_next_i    (pc_next_ifid),
		.fwd_en_i     (reg_write_exmem),
		.fwd_idx_i    (dst_exmem),
		.fwd_data_i   (alu_res_exmem),
		.wb_en_i      (wb_en_o),
		.wb_idx_i     (wb_reg_o),
		.wb_data_i    (wb_data_o),
		.src_a_idx_o  (src_a_idx_id),
		.src_b_idx_o  (src_b_idx_id),
		.is_branch_o  (is_branch_id),
		.alu_op_o     (alu_op_idex),
		.op_a_o       (op_a_idex),
		.op_b_o       (op_b_idex),
		.imm_sel_o    (imm_sel_idex),
		.src_a_o      (src_a_idex),
		.src_b_o      (src_b_idex),
		.store_data_o (store_data_idex),
		.dst_o        (dst_idex),
		.reg_write_o  (reg_write_idex),
		.mem_read_o   (mem_read_idex),
		.mem_write_o  (mem_write_idex)
	);

	//////////////////////////////////////////////////////////////////////
	// EX, MEM, WB
	//////////////////////////////////////////////////////////////////////

	execute_stage _execute (
		.clk          (clk),
		.reset_i      (reset_i),
		.alu_op_i     (alu_op_idex),
		.op_a_i       (op_a_idex),
		.op_b_i       (op_b_idex),
		.imm_sel_i    (imm_sel_idex),
		.src_a_i      (src_a_idex),
		.src_b_i      (src_b_idex),
		.store_data_i (store_data_idex),
		.dst_i        (dst_idex),
		.reg_write_i  (reg_write_idex),
		.mem_read_i   (mem_read_idex),
		.mem_write_i  (mem_write_idex),
		.wb_en_i      (wb_en_o),
		.wb_idx_i     (wb_reg_o),
		.wb_data_i    (wb_data_o),
		.alu_res_o    (alu_res_exmem),
		.store_data_o (store_data_exmem),
		.dst_o        (dst_exmem),
		.reg_write_o  (reg_write_exmem),
		.mem_read_o   (mem_read_exmem),
		.mem_write_o  (mem_write_exmem)
	);

	memory_writeback _mem_wb (
		.clk          (clk),
		.reset_i      (reset_i),
		.alu_res_i    (alu_res_exmem),
		.store_data_i (store_data_exmem),
		.dst_i        (dst_exmem),
		.reg_write_i  (reg_write_exmem),
		.mem_read_i   (mem_read_exmem),
		.mem_write_i  (mem_write_exmem),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_re_o    (dmem_re_o),
		.dmem_rdata_i (dmem_rdata_i),
		.wb_en_o      (wb_en_o),
		.wb_idx_o     (wb_reg_o),
		.wb_data_o    (wb_data_o)
	);

	// load-use and branch operand hazards
	hazard_unit _hazard (
		.clk            (clk),
		.reset_i        (reset_i),
		.hz             (hz),
		.src_a_idx_i    (src_a_idx_id),
		.src_b_idx_i    (src_b_idx_id),
		.id_is_branch_i (is_branch_id),
		.idex_dst_i     (dst_idex),
		.idex_write_i   (reg_write_idex),
		.idex_load_i    (mem_read_idex),
		.exmem_dst_i    (dst_exmem),
		.exmem_load_i   (mem_read_exmem)
	);

endmodule

// ==== testbench/cpu_properties.sv ====
`timescale 1ns/1ns

module cpu_properties
	import cpu_pkg::*;
(
	input logic              clk,
	input logic              reset_i,
	input logic              wb_en_o,
	input logic              dmem_we_o,
	input logic              dmem_re_o,
	input logic [REG_W-1:0]  wb_reg_o,
	input logic [WORD_W-1:0] wb_data_o
);

	// quiet through reset and the cycle after
	quiet_after_reset: assert property (@(posedge clk)
		reset_i |=> (!wb_en_o && !dmem_we_o && !dmem_re_o))
		else $error("strobe active during or right after reset");

	// one memory access per cycle
	no_read_and_write: assert property (@(posedge clk) disable iff (reset_i)
		!(dmem_we_o && dmem_re_o))
		else $error("dmem read and write strobes high together");

	// retirement record fully known
	wb_known: assert property (@(posedge clk) disable iff (reset_i)
		wb_en_o |-> !$isunknown({wb_reg_o, wb_data_o}))
		else $error("write-back index or data unknown");

endmodule

bind cpu_top cpu_properties props_i (.*);

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb
	import cpu_pkg::*;
();

	// first fetch address, off zero so the reset pc is visible
	localparam logic [WORD_W-1:0] PC_RESET = 16'h0010;
	localparam int CLK_HALF   = 20;
	localparam int DRIVE_DLY  = 2;
	localparam int IMEM_DEPTH = 256;
	// data window of loads and stores, -16 .. 15
	localparam int WIN = 32;

	// one retired instruction as the model sees it
	typedef struct packed {
		logic              wr;
		logic [REG_W-1:0]  idx;
		logic [WORD_W-1:0] data;
		logic              st;
		logic [WORD_W-1:0] addr;
		logic [WORD_W-1:0] sdata;
		logic [WORD_W-1:0] npc;
	} step_t;

	typedef logic [WORD_W-1:0] regs_t [2**REG_W];
	typedef logic [WORD_W-1:0] win_t [WIN];

	logic              clk;
	logic              reset_i;
	logic [WORD_W-1:0] imem_addr_o;
	logic [WORD_W-1:0] imem_data_i;
	logic [WORD_W-1:0] dmem_addr_o;
	logic [WORD_W-1:0] dmem_wdata_o;
	logic              dmem_we_o;
	logic              dmem_re_o;
	logic [WORD_W-1:0] dmem_rdata_i;
	logic              wb_en_o;
	logic [REG_W-1:0]  wb_reg_o;
	logic [WORD_W-1:0] wb_data_o;

	logic [WORD_W-1:0] imem [IMEM_DEPTH];
	logic [WORD_W-1:0] dmem [65536];
	step_t             exp_wb [$];
	step_t             exp_st [$];
	logic [31:0]       lfsr_q;
	string             test_name;
	logic              checking;
	int                cycle_cnt;
	int                start_cycle;
	int                budget;

	cpu_top #(
		.PC_RESET (PC_RESET)
	) dut_i (
		.clk          (clk),
		.reset_i      (reset_i),
		.imem_addr_o  (imem_addr_o),
		.imem_data_i  (imem_data_i),
		.dmem_addr_o  (dmem_addr_o),
		.dmem_wdata_o (dmem_wdata_o),
		.dmem_we_o    (dmem_we_o),
		.dmem_re_o    (dmem_re_o),
		.dmem_rdata_i (dmem_rdata_i),
		.wb_en_o      (wb_en_o),
		.wb_reg_o     (wb_reg_o),
		.wb_data_o    (wb_data_o)
	);

	//////////////////////////////////////////////////////////////////////
	// clock and memory models
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever begin
			#CLK_HALF clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// imem outside the array reads as nop
	assign imem_data_i  = (imem_addr_o < IMEM_DEPTH) ? imem[imem_addr_o[7:0]] : '0;
	// dmem answers only while the read strobe is high, writes at the edge
	assign dmem_rdata_i = dmem_re_o ? dmem[dmem_addr_o] : 'x;

	always @(posedge clk) begin
		if (dmem_we_o) begin
			dmem[dmem_addr_o] <= dmem_wdata_o;
		end
	end

	// background pattern over the whole address
	function automatic logic [WORD_W-1:0] fill_word(input logic [WORD_W-1:0] a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ 16'h3c5a;
	endfunction

	function automatic logic [WORD_W-1:0] win_addr(input int k);
		logic [WORD_W-1:0] t;
		t = k[WORD_W-1:0];
		return t - 16'd16;
	endfunction

	function automatic int win_index(input logic [WORD_W-1:0] a);
		return int'(a[4:0] ^ 5'h10);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// failure reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_reg(input string name, input logic [REG_W-1:0] ei,
		input logic [WORD_W-1:0] ed, input logic [REG_W-1:0] ai,
		input logic [WORD_W-1:0] ad);
		if (ai !== ei || ad !== ed) begin
			abort_run($sformatf("ERR %s expected r%0d=%h actual r%0d=%h",
				name, ei, ed, ai, ad));
		end
	endtask

	task automatic check_store(input string name, input logic [WORD_W-1:0] ea,
		input logic [WORD_W-1:0] ed, input logic [WORD_W-1:0] aa,
		input logic [WORD_W-1:0] ad);
		if (aa !== ea || ad !== ed) begin
			abort_run($sformatf("ERR %s expected mem[%h]=%h actual mem[%h]=%h",
				name, ea, ed, aa, ad));
		end
	endtask

	task automatic check_word(input string name, input logic [WORD_W-1:0] e,
		input logic [WORD_W-1:0] a);
		if (a !== e) begin
			abort_run($sformatf("ERR %s expected %h actual %h", name, e, a));
		end
	endtask

	task automatic check_bit(input string name, input logic e, input logic a);
		if (a !== e) begin
			abort_run($sformatf("ERR %s expected %b actual %b", name, e, a));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	function automatic step_t ref_step(input instr_t ins, input regs_t r,
		input win_t m, input logic [WORD_W-1:0] pc);
		step_t             s;
		logic [WORD_W-1:0] imm;
		logic [WORD_W-1:0] ea;
		s     = '0;
		s.npc = pc + 16'd1;
		imm   = {{(WORD_W-5){ins.i.imm[4]}}, ins.i.imm};
		ea    = r[ins.i.ry] + imm;
		case (ins.r.opcode)
			OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_SLT: begin
				s.wr  = 1'b1;
				s.idx = ins.r.rd;
				case (ins.r.opcode)
					OP_ADDU: s.data = r[ins.r.rs] + r[ins.r.rt];
					OP_SUBU: s.data = r[ins.r.rs] - r[ins.r.rt];
					OP_AND:  s.data = r[ins.r.rs] & r[ins.r.rt];
					OP_OR:   s.data = r[ins.r.rs] | r[ins.r.rt];
					default: s.data = ($signed(r[ins.r.rs]) < $signed(r[ins.r.rt])) ? 16'd1 : 16'd0;
				endcase
			end
			OP_ADDIU: begin
				s.wr   = 1'b1;
				s.idx  = ins.i.rx;
				s.data = ea;
			end
			OP_LW: begin
				s.wr   = 1'b1;
				s.idx  = ins.i.rx;
				s.data = m[win_index(ea)];
				s.addr = ea;
			end
			OP_SW: begin
				s.st    = 1'b1;
				s.addr  = ea;
				s.sdata = r[ins.i.rx];
			end
			OP_BEQZ: begin
				if (r[ins.i.ry] == '0) begin
					s.npc = pc + 16'd1 + imm;
				end
			end
			default: begin
			end
		endcase
		return s;
	endfunction

	// walk the program in order, queue the expected events
	task automatic build_expect(input int len, output int steps);
		regs_t             r;
		win_t              m;
		step_t             s;
		instr_t            ins;
		logic [WORD_W-1:0] pc;
		for (int k = 0; k < 2**REG_W; k++) begin
			r[k] = '0;
		end
		for (int k = 0; k < WIN; k++) begin
			m[k] = fill_word(win_addr(k));
		end
		pc    = PC_RESET;
		steps = 0;
		while (pc >= PC_RESET && pc < PC_RESET + len && steps < 1000) begin
			ins = instr_t'(imem[pc[7:0]]);
			s   = ref_step(ins, r, m, pc);
			if ((s.st || ins.r.opcode == OP_LW) &&
				WORD_W'(s.addr + 16'd16) >= WIN) begin
				abort_run($sformatf("%s: program reaches address %h outside the data window",
					test_name, s.addr));
			end
			if (s.wr) begin
				r[s.idx] = s.data;
				exp_wb.push_back(s);
			end
			if (s.st) begin
				m[win_index(s.addr)] = s.sdata;
				exp_st.push_back(s);
			end
			pc = s.npc;
			steps++;
		end
		if (steps >= 1000) begin
			abort_run($sformatf("%s: program does not terminate in the model", test_name));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// compare process and watchdog
	//////////////////////////////////////////////////////////////////////

	// outputs settle after the edge, sample mid-cycle
	always @(negedge clk) begin
		step_t s;
		if (checking && !reset_i) begin
			if (wb_en_o) begin
				if (exp_wb.size() == 0) begin
					abort_run($sformatf("%s: write-back to r%0d with nothing left to retire",
						test_name, wb_reg_o));
				end else begin
					s = exp_wb.pop_front();
					check_reg(test_name, s.idx, s.data, wb_reg_o, wb_data_o);
				end
			end
			if (dmem_we_o) begin
				if (exp_st.size() == 0) begin
					abort_run($sformatf("%s: store to %h that the program never makes",
						test_name, dmem_addr_o));
				end else begin
					s = exp_st.pop_front();
					check_store(test_name, s.addr, s.sdata, dmem_addr_o, dmem_wdata_o);
				end
			end
		end
	end

	// budget is 6 cycles per executed instruction plus 50
	initial begin
		forever begin
			@(posedge clk);
			if (budget > 0 && cycle_cnt - start_cycle > budget) begin
				abort_run($sformatf("%s: watchdog expired after %0d cycles",
					test_name, budget));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// program generation
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v      = {v[14:0], lfsr_q[0]};
		end
	endtask

	task automatic put_r(input int a, input logic [4:0] op, input int rd, input int rs,
		input int rt);
		instr_t w;
		w.r.opcode = op;
		w.r.rd     = rd[REG_W-1:0];
		w.r.rs     = rs[REG_W-1:0];
		w.r.rt     = rt[REG_W-1:0];
		w.r.spare  = 2'b00;
		imem[PC_RESET + a] = w;
	endtask

	task automatic put_i(input int a, input logic [4:0] op, input int rx, input int ry,
		input int imm);
		instr_t w;
		w.i.opcode = op;
		w.i.rx     = rx[REG_W-1:0];
		w.i.ry     = ry[REG_W-1:0];
		w.i.imm    = imm[4:0];
		imem[PC_RESET + a] = w;
	endtask

	// reset held while the next program is loaded
	task automatic begin_test(input string name);
		@(posedge clk);
		#DRIVE_DLY;
		reset_i   = 1'b1;
		checking  = 1'b0;
		test_name = name;
		exp_wb.delete();
		exp_st.delete();
		for (int k = 0; k < IMEM_DEPTH; k++) begin
			imem[k] = '0;
		end
	endtask

	task automatic finish_test(input int len);
		int steps;
		build_expect(len, steps);
		start_cycle = cycle_cnt;
		budget      = 6 * steps + 50;
		repeat (5) @(posedge clk);
		for (int k = 0; k < 65536; k++) begin
			dmem[k] = fill_word(k[WORD_W-1:0]);
		end
		checking = 1'b1;
		#DRIVE_DLY;
		reset_i = 1'b0;
		// nothing retires before the first instruction can
		for (int k = 0; k < 3; k++) begin
			@(negedge clk);
			if (k == 0) begin
				check_word({test_name, " first fetch"}, PC_RESET, imem_addr_o);
			end
			check_bit({test_name, " wb_en_o early"}, 1'b0, wb_en_o);
			check_bit({test_name, " dmem_we_o early"}, 1'b0, dmem_we_o);
			check_bit({test_name, " dmem_re_o early"}, 1'b0, dmem_re_o);
		end
		while (exp_wb.size() != 0 || exp_st.size() != 0) begin
			@(posedge clk);
		end
		// trailing nops, nothing more may retire
		repeat (8) @(posedge clk);
		checking = 1'b0;
		budget   = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] sel;
		logic [15:0] v;
		logic [15:0] b;
		int          prev;
		int          rd;
		reset_i   = 1'b1;
		checking  = 1'b0;
		budget    = 0;
		cycle_cnt = 0;
		lfsr_q    = 32'ha9c3_3300;
		test_name = "init";
		for (int k = 0; k < IMEM_DEPTH; k++) begin
			imem[k] = '0;
		end
		for (int k = 0; k < 65536; k++) begin
			dmem[k] = fill_word(k[WORD_W-1:0]);
		end

		// reset state, one instruction
		begin_test("reset");
		put_i(0, OP_ADDIU, 1, 0, 7);
		finish_test(1);

		// back-to-back alu dependences
		begin_test("alu_random");
		prev = 0;
		for (int n = 0; n < 24; n++) begin
			take_bits(3, sel);
			take_bits(3, v);
			rd = v;
			take_bits(1, b);
			if (b[0] == 1'b0) begin
				take_bits(3, v);
				prev = v;
			end
			take_bits(3, v);
			if (sel < 5) begin
				put_r(n, OP_ADDU + sel[4:0], rd, prev, v);
			end else begin
				put_i(n, OP_ADDIU, rd, prev, v + 13);
			end
			prev = rd;
		end
		finish_test(24);

		// loads and stores off r7, which stays zero
		begin_test("mem_random");
		put_i(0, OP_LW, 1, 7, 3);
		put_r(1, OP_ADDU, 2, 1, 1);
		prev = 2;
		for (int n = 2; n < 26; n++) begin
			take_bits(2, sel);
			take_bits(3, v);
			rd = (v == 7) ? 6 : v;
			take_bits(5, b);
			if (sel < 2) begin
				put_i(n, OP_LW, rd, 7, b);
				prev = rd;
			end else if (sel == 2) begin
				put_i(n, OP_SW, v, 7, b);
			end else begin
				put_i(n, OP_ADDIU, rd, prev, b);
				prev = rd;
			end
		end
		finish_test(26);

		// countdown loop, counter made right before the branch
		begin_test("branch_loop");
		put_i(0, OP_ADDIU, 1, 0, 5);
		put_i(1, OP_ADDIU, 2, 2, 1);
		put_i(2, OP_ADDIU, 1, 1, -1);
		put_i(3, OP_BEQZ, 0, 1, 1);
		put_i(4, OP_BEQZ, 0, 0, -4);
		put_r(5, OP_OR, 3, 1, 2);
		put_i(6, OP_SW, 2, 0, 0);
		// lw then beqz on it, two stall cycles
		put_i(7, OP_LW, 5, 0, 0);
		put_i(8, OP_BEQZ, 0, 5, 2);
		put_i(9, OP_ADDIU, 6, 5, 1);
		finish_test(10);

		// consumer in ID while producer writes back
		begin_test("rf_bypass");
		put_i(0, OP_ADDIU, 1, 7, 9);
		put_r(3, OP_ADDU, 2, 1, 1);
		put_i(4, OP_ADDIU, 3, 7, -3);
		put_i(7, OP_SW, 3, 7, 2);
		finish_test(8);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

// ==== flist.f ====
source/cpu_pkg.sv
source/hazard_if.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/hazard_unit.sv
source/cpu_top.sv
testbench/cpu_properties.sv
testbench/cpu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cpu_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
